// File: filelist.f
+incdir+test
hdl/pipePkg.sv
hdl/dataMemory.sv
hdl/memWbReg.sv
hdl/writeBackStage.sv
hdl/registerFile.sv
hdl/memBackEnd.sv
test/memBackEndTb.sv

// File: hdl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory
	import pipePkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  exMemT             exMem,
	output logic              memStall,
	output logic [DATA_W-1:0] memData,
	output logic              misalign
);

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [MEM_ADDR_W-1:0] wordAddr;
	logic memAccess;
	logic accessReq;
	logic secondPhase;

	// addresses are byte addresses. A word access needs bit 0 clear.
	assign memAccess = exMem.ctrl.memRead | exMem.ctrl.memWrite;
	assign misalign = memAccess & exMem.aluOut[0];
	assign accessReq = memAccess & ~exMem.aluOut[0];

	// bit 0 is dropped to turn the byte address into a word index.
	assign wordAddr = exMem.aluOut[MEM_ADDR_W:1];

	// the first cycle of an aligned access stalls.
	// The upstream stage holds exMem, so the second cycle sees the same request.
	assign memStall = accessReq & ~secondPhase;

	always_ff @(posedge clk) begin
		if (rst) begin
			secondPhase <= 1'b0;
		end else begin
			secondPhase <= memStall;
		end
	end

	// the store lands at the edge that ends the stall cycle.
	always_ff @(posedge clk) begin
		if (memStall && exMem.ctrl.memWrite) begin
			mem[wordAddr] <= exMem.storeData;
		end
	end

	// the read word is registered at the same edge.
	// It is presented through the second cycle of the access.
	always_ff @(posedge clk) begin
		if (memStall) begin
			memData <= mem[wordAddr];
		end
	end

	// every access takes exactly one stall cycle, even back to back.
	stallOneCycle: assert property (
		@(posedge clk) disable iff (rst)
		memStall |=> !memStall
	) else $error("memStall high in two consecutive cycles");

	// the data phase always follows a stall, so the access is still present.
	dataPhaseHasAccess: assert property (
		@(posedge clk) disable iff (rst)
		memStall |=> accessReq
	) else $error("access request withdrawn during the data phase");

endmodule

// File: hdl/memBackEnd.sv
`timescale 1ns/1ps

module memBackEnd
	import pipePkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  exMemT                exMem,
	input  logic [REG_SEL_W-1:0] rdAddr,
	output logic                 memStall,
	output logic [DATA_W-1:0]    rdData,
	output logic                 halted,
	output logic                 error
);

	logic [DATA_W-1:0] memData;
	logic misalign;
	memWbT memWb;
	logic wrEn;
	logic [REG_SEL_W-1:0] wrSel;
	logic [DATA_W-1:0] wrData;

	dataMemory dataMemory0 (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.memStall(memStall),
		.memData(memData),
		.misalign(misalign)
	);

	memWbReg memWbReg0 (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.memData(memData),
		.memStall(memStall),
		.misalign(misalign),
		.memWb(memWb)
	);

	writeBackStage writeBackStage0 (
		.clk(clk),
		.rst(rst),
		.memWb(memWb),
		.wrEn(wrEn),
		.wrSel(wrSel),
		.wrData(wrData),
		.halted(halted),
		.error(error)
	);

	registerFile registerFile0 (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrSel(wrSel),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

endmodule

// File: hdl/memWbReg.sv
`timescale 1ns/1ps

module memWbReg
	import pipePkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  exMemT             exMem,
	input  logic [DATA_W-1:0] memData,
	input  logic              memStall,
	input  logic              misalign,
	output memWbT             memWb
);

	ctrlT ctrlQ;
	logic errQ;
	logic [DATA_W-1:0] pcPlus2Q;
	logic [DATA_W-1:0] aluOutQ;
	logic [DATA_W-1:0] memDataQ;
	logic [REG_SEL_W-1:0] writeRegSelQ;

	// control state. A misaligned access is folded into the error bit here.
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlQ <= CTRL_NOP;
			errQ <= 1'b0;
		end else if (!memStall) begin
			ctrlQ <= exMem.ctrl;
			errQ <= exMem.err | misalign;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			pcPlus2Q <= exMem.pcPlus2;
			aluOutQ <= exMem.aluOut;
			memDataQ <= memData;
			writeRegSelQ <= exMem.writeRegSel;
		end
	end

	// the held instruction is retired one cycle late.
	// Its control reads as a nop during the stall so it writes back only once.
	always_comb begin
		memWb.ctrl = memStall ? CTRL_NOP : ctrlQ;
		memWb.pcPlus2 = pcPlus2Q;
		memWb.aluOut = aluOutQ;
		memWb.memData = memDataQ;
		memWb.writeRegSel = writeRegSelQ;
		memWb.err = errQ;
	end

	holdDuringStall: assert property (
		@(posedge clk) disable iff (rst)
		memStall |=> $stable({ctrlQ, errQ, pcPlus2Q, aluOutQ, memDataQ, writeRegSelQ})
	) else $error("MEM/WB contents changed during a memory stall");

	// the execute stage must keep its result steady until the access completes.
	upstreamHold: assert property (
		@(posedge clk) disable iff (rst)
		memStall |=> $stable(exMem)
	) else $error("exMem changed while memStall was high");

endmodule

// File: hdl/pipePkg.sv
package pipePkg;

	localparam int DATA_W = 16;
	localparam int REG_SEL_W = 3;
	localparam int MEM_DEPTH = 256;

	// derived sizes for the memory word index and the register array.
	localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);
	localparam int NUM_REGS = 1 << REG_SEL_W;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC
	} wbSelT;

	// haltN is active low, so a cleared bit stops the machine.
	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic regWrite;
		wbSelT wbSel;
		logic haltN;
	} ctrlT;

	localparam ctrlT CTRL_NOP = '{
		memRead: 1'b0,
		memWrite: 1'b0,
		regWrite: 1'b0,
		wbSel: WB_ALU,
		haltN: 1'b1
	};

	// aluOut doubles as the byte address for loads and stores.
	typedef struct packed {
		ctrlT ctrl;
		logic [DATA_W-1:0] pcPlus2;
		logic [DATA_W-1:0] aluOut;
		logic [DATA_W-1:0] storeData;
		logic [REG_SEL_W-1:0] writeRegSel;
		logic err;
	} exMemT;

	typedef struct packed {
		ctrlT ctrl;
		logic [DATA_W-1:0] pcPlus2;
		logic [DATA_W-1:0] aluOut;
		logic [DATA_W-1:0] memData;
		logic [REG_SEL_W-1:0] writeRegSel;
		logic err;
	} memWbT;

endpackage

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile
	import pipePkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wrEn,
	input  logic [REG_SEL_W-1:0] wrSel,
	input  logic [DATA_W-1:0]    wrData,
	input  logic [REG_SEL_W-1:0] rdAddr,
	output logic [DATA_W-1:0]    rdData
);

	logic [DATA_W-1:0] regs [NUM_REGS];

	// register 0 is an ordinary register here and takes writes like the rest.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	// the read is combinational. A write shows up after the edge.
	assign rdData = regs[rdAddr];

endmodule

// File: hdl/writeBackStage.sv
`timescale 1ns/1ps

module writeBackStage
	import pipePkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  memWbT                memWb,
	output logic                 wrEn,
	output logic [REG_SEL_W-1:0] wrSel,
	output logic [DATA_W-1:0]    wrData,
	output logic                 halted,
	output logic                 error
);

	// writeback source select.
	always_comb begin
		case (memWb.ctrl.wbSel)
			WB_MEM: begin
				wrData = memWb.memData;
			end
			WB_PC: begin
				wrData = memWb.pcPlus2;
			end
			default: begin
				wrData = memWb.aluOut;
			end
		endcase
	end

	assign wrSel = memWb.writeRegSel;

	// once halted nothing more reaches the register file.
	assign wrEn = memWb.ctrl.regWrite & ~halted;

	// both flags stay set until reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (!memWb.ctrl.haltN) begin
			halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			error <= 1'b0;
		end else if (memWb.err) begin
			error <= 1'b1;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module memBackEndTb -f filelist.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: test/memBackEndTable.svh
	// each row holds ctrl, pcPlus2, aluOut, storeData, writeRegSel, err, random aluOut,
	// reset before the row, register read back and the expected {halted, error} after the row.
	localparam int numRows = 23;

	rowT rows [numRows] = '{
		'{ctlAlu,   16'h0002, 16'h1234, 16'h0000, 3'd1, 1'b0, 1'b0, 1'b0, 3'd1, 2'b00},
		'{ctlAlu,   16'h0004, 16'hbeef, 16'h0000, 3'd0, 1'b0, 1'b0, 1'b0, 3'd0, 2'b00},
		'{ctlAlu,   16'h0006, 16'h0000, 16'h0000, 3'd2, 1'b0, 1'b1, 1'b0, 3'd2, 2'b00},
		'{ctlAlu,   16'h0008, 16'h0000, 16'h0000, 3'd7, 1'b0, 1'b1, 1'b0, 3'd7, 2'b00},
		'{ctlStore, 16'h000a, 16'h0010, 16'ha5a5, 3'd0, 1'b0, 1'b0, 1'b0, 3'd1, 2'b00},
		'{ctlStore, 16'h000c, 16'h00fe, 16'h5a5a, 3'd0, 1'b0, 1'b0, 1'b0, 3'd0, 2'b00},
		'{ctlLoad,  16'h000e, 16'h0010, 16'h0000, 3'd3, 1'b0, 1'b0, 1'b0, 3'd3, 2'b00},
		'{ctlLoad,  16'h0010, 16'h00fe, 16'h0000, 3'd4, 1'b0, 1'b0, 1'b0, 3'd4, 2'b00},
		'{ctlPc,    16'h0042, 16'h0000, 16'h0000, 3'd5, 1'b0, 1'b0, 1'b0, 3'd5, 2'b00},
		'{ctlAlu,   16'h0044, 16'h1111, 16'h0000, 3'd3, 1'b0, 1'b0, 1'b0, 3'd3, 2'b00},
		'{ctlLoad,  16'h0046, 16'h0010, 16'h0000, 3'd3, 1'b0, 1'b0, 1'b0, 3'd3, 2'b00},
		'{ctlStore, 16'h0048, 16'h01fe, 16'h0f0f, 3'd0, 1'b0, 1'b0, 1'b0, 3'd0, 2'b00},
		'{ctlLoad,  16'h004a, 16'h01fe, 16'h0000, 3'd6, 1'b0, 1'b0, 1'b0, 3'd6, 2'b00},
		'{ctlAlu,   16'h004c, 16'h0000, 16'h0000, 3'd2, 1'b0, 1'b1, 1'b0, 3'd2, 2'b00},
		'{ctlStore, 16'h004e, 16'h0011, 16'hdead, 3'd0, 1'b0, 1'b0, 1'b0, 3'd1, 2'b01},
		'{ctlAlu,   16'h0050, 16'h0000, 16'h0000, 3'd1, 1'b0, 1'b1, 1'b0, 3'd1, 2'b01},
		'{ctlLoad,  16'h0052, 16'h00fe, 16'h0000, 3'd4, 1'b0, 1'b0, 1'b0, 3'd4, 2'b01},
		'{ctlHalt,  16'h0054, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0, 1'b0, 3'd1, 2'b11},
		'{ctlAlu,   16'h0056, 16'h7777, 16'h0000, 3'd1, 1'b0, 1'b0, 1'b0, 3'd1, 2'b11},
		'{ctlLoad,  16'h0058, 16'h0010, 16'h0000, 3'd3, 1'b0, 1'b0, 1'b0, 3'd3, 2'b11},
		'{ctlPc,    16'h005a, 16'h0000, 16'h0000, 3'd5, 1'b0, 1'b0, 1'b0, 3'd5, 2'b11},
		'{ctlAlu,   16'h005c, 16'h0abc, 16'h0000, 3'd2, 1'b1, 1'b0, 1'b1, 3'd2, 2'b01},
		'{ctlAlu,   16'h005e, 16'h0000, 16'h0000, 3'd6, 1'b0, 1'b1, 1'b0, 3'd6, 2'b01}
	};

// File: test/memBackEndTb.sv
`timescale 1ns/1ps

module memBackEndTb
	import pipePkg::*;
();

	localparam int clkPeriod = 100;
	localparam int settle = clkPeriod / 4;

	typedef struct packed {
		ctrlT ctrl;
		logic [DATA_W-1:0] pc;
		logic [DATA_W-1:0] alu;
		logic [DATA_W-1:0] st;
		logic [REG_SEL_W-1:0] wsel;
		logic err;
		logic rnd;
		logic rstFirst;
		logic [REG_SEL_W-1:0] rdReg;
		logic [1:0] flags;
	} rowT;

	localparam ctrlT ctlAlu = '{1'b0, 1'b0, 1'b1, WB_ALU, 1'b1};
	localparam ctrlT ctlLoad = '{1'b1, 1'b0, 1'b1, WB_MEM, 1'b1};
	localparam ctrlT ctlStore = '{1'b0, 1'b1, 1'b0, WB_ALU, 1'b1};
	localparam ctrlT ctlPc = '{1'b0, 1'b0, 1'b1, WB_PC, 1'b1};
	localparam ctrlT ctlHalt = '{1'b0, 1'b0, 1'b0, WB_ALU, 1'b0};

`include "memBackEndTable.svh"

	logic clk;
	logic rst;
	exMemT exMem;
	logic [REG_SEL_W-1:0] rdAddr;
	logic memStall;
	logic [DATA_W-1:0] rdData;
	logic halted;
	logic error;

	logic [DATA_W-1:0] modelRegs [NUM_REGS];
	logic [DATA_W-1:0] modelMem [MEM_DEPTH];
	logic modelHalted;
	integer seed = 13;

	memBackEnd dut0 (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.rdAddr(rdAddr),
		.memStall(memStall),
		.rdData(rdData),
		.halted(halted),
		.error(error)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2) clk = 1'b1;
			#(clkPeriod / 2) clk = 1'b0;
		end
	end

	// a memory row needs three falling edges and a reset row some more.
	initial begin
		#((numRows * 5 + 20) * clkPeriod);
		$display("Timeout: the table did not finish within the allowed number of cycles");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	task checkEq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task driveNop();
		exMem = '0;
		exMem.ctrl = CTRL_NOP;
	endtask

	// called on a falling edge. The memory contents survive reset.
	task doReset();
		rst = 1'b1;
		driveNop();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			modelRegs[i] = '0;
		end
		modelHalted = 1'b0;
	endtask

	task checkAfterReset();
		for (int i = 0; i < NUM_REGS; i++) begin
			rdAddr = i[REG_SEL_W-1:0];
			#settle;
			checkEq(rdData, '0, "register clear after reset");
			checkEq({13'b0, memStall, halted, error}, '0, "stall and flags low after reset");
			@(negedge clk);
		end
	endtask

	task runRow(input rowT row);
		rowT cur;
		integer rndWord;
		int stalls;
		int expStalls;
		logic access;
		logic mis;
		logic [DATA_W-1:0] oldVal;
		logic [DATA_W-1:0] loadVal;
		logic [DATA_W-1:0] wbVal;
		cur = row;
		rndWord = $random(seed);
		if (cur.rnd) begin
			cur.alu = rndWord[DATA_W-1:0];
		end
		if (cur.rstFirst) begin
			doReset();
			checkAfterReset();
		end
		oldVal = modelRegs[cur.wsel];
		exMem.ctrl = cur.ctrl;
		exMem.pcPlus2 = cur.pc;
		exMem.aluOut = cur.alu;
		exMem.storeData = cur.st;
		exMem.writeRegSel = cur.wsel;
		exMem.err = cur.err;
		rdAddr = cur.wsel;
		stalls = 0;
		#settle;
		checkEq(rdData, oldVal, "register changed while the row was in flight");
		while (memStall) begin
			stalls++;
			@(negedge clk);
			#settle;
		end
		@(negedge clk);
		// a load that retired during its stall would already show a stale word here.
		checkEq(rdData, oldVal, "register written before the row retired");
		driveNop();
		rdAddr = cur.rdReg;

		// expected result from the writeback rules.
		access = cur.ctrl.memRead | cur.ctrl.memWrite;
		mis = access & cur.alu[0];
		expStalls = (access && !mis) ? 1 : 0;
		loadVal = modelMem[cur.alu[MEM_ADDR_W:1]];
		if (cur.ctrl.memWrite && !mis) begin
			modelMem[cur.alu[MEM_ADDR_W:1]] = cur.st;
		end
		case (cur.ctrl.wbSel)
			WB_MEM: wbVal = loadVal;
			WB_PC: wbVal = cur.pc;
			default: wbVal = cur.alu;
		endcase
		// a halting row that writes a register still does so. The flag only rises after it.
		if (cur.ctrl.regWrite && !modelHalted) begin
			modelRegs[cur.wsel] = wbVal;
		end
		if (!cur.ctrl.haltN) begin
			modelHalted = 1'b1;
		end

		@(negedge clk);
		checkEq(rdData, modelRegs[cur.rdReg], "register read back");
		checkEq(16'(stalls), 16'(expStalls), "memStall cycles for the row");
		checkEq({14'b0, halted, error}, {14'b0, cur.flags}, "halted and error flags");
	endtask

	initial begin
		rst = 1'b1;
		driveNop();
		rdAddr = '0;
		modelHalted = 1'b0;
		@(negedge clk);
		doReset();
		checkAfterReset();
		for (int i = 0; i < numRows; i++) begin
			runRow(rows[i]);
		end
		$display("Everything OK");
		$finish;
	end

endmodule
